//--- hw/sifhPkg.sv
package sifhPkg;

    localparam int CodeW = 10;
    localparam int BinW = 4;
    localparam int NumBins = 16;
    localparam int CountW = 8; // counts saturate at all ones

    // first pass bins on the top bits
    typedef struct packed {
        logic [BinW-1:0]       coarseBin;
        logic [CodeW-BinW-1:0] residue;
    } coarseView_t;

    // second pass keeps window hits, bins on the next bits down
    typedef struct packed {
        logic [BinW-1:0]         window;
        logic [BinW-1:0]         fineBin;
        logic [CodeW-2*BinW-1:0] lsb; // below fine resolution
    } fineView_t;

    typedef union packed {
        coarseView_t coarse;
        fineView_t   fine;
    } tdcCode_u;

endpackage

//--- hw/hisRam.sv
module hisRam (
    input  logic                       clk,
    input  logic                       we,
    input  logic [sifhPkg::BinW-1:0]   waddr,
    input  logic [sifhPkg::CountW-1:0] wdata,
    input  logic                       re,
    input  logic [sifhPkg::BinW-1:0]   raddr,
    output logic [sifhPkg::CountW-1:0] rdata
);
    import sifhPkg::*;

    logic [CountW-1:0] mem [NumBins]; // contents undefined until cleared

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr]; // old data on same-address write
        end
    end

endmodule

//--- hw/hisBuilder.sv
module hisBuilder (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       binValid,
    input  logic [sifhPkg::BinW-1:0]   binIndex,
    input  logic [sifhPkg::CountW-1:0] rdata,
    output logic                       re,
    output logic [sifhPkg::BinW-1:0]   raddr,
    output logic                       we,
    output logic [sifhPkg::BinW-1:0]   waddr,
    output logic [sifhPkg::CountW-1:0] wdata,
    output logic                       idle
);
    import sifhPkg::*;

    logic              stgValid; // event waiting for its read data
    logic [BinW-1:0]   stgBin;
    logic              lastWe;   // write issued last cycle
    logic [BinW-1:0]   lastAddr;
    logic [CountW-1:0] lastData;
    logic [CountW-1:0] curCount;

    // stage 1, read the bin as the strobe arrives
    assign re = binValid;
    assign raddr = binIndex;

    // a write from the previous cycle is not yet visible in rdata
    assign curCount = (lastWe && lastAddr == stgBin) ? lastData : rdata;

    // stage 2, increment and write back
    assign we = stgValid;
    assign waddr = stgBin;
    assign wdata = (curCount == '1) ? curCount : curCount + 1'b1; // saturate

    assign idle = ~binValid & ~stgValid;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            stgValid <= 1'b0;
            lastWe <= 1'b0;
        end else begin
            stgValid <= binValid;
            lastWe <= we;
        end
    end

    always_ff @(posedge clk) begin
        stgBin <= binIndex;
        lastAddr <= waddr;
        lastData <= wdata;
    end

endmodule

//--- hw/peakFinder.sv
module peakFinder (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       start,
    input  logic [sifhPkg::CountW-1:0] rdata,
    output logic                       re,
    output logic [sifhPkg::BinW-1:0]   raddr,
    output logic                       found,
    output logic [sifhPkg::BinW-1:0]   peakBin,
    output logic [sifhPkg::CountW-1:0] peakVal
);
    import sifhPkg::*;

    logic            cmpValid; // rdata holds the bin at cmpAddr
    logic [BinW-1:0] cmpAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            re <= 1'b0;
            raddr <= '0;
            cmpValid <= 1'b0;
            found <= 1'b0;
            peakBin <= '0;
            peakVal <= '0;
        end else begin
            cmpValid <= re;
            found <= cmpValid && (cmpAddr == BinW'(NumBins - 1));

            // strictly greater, so the lowest bin keeps a tie
            if (cmpValid && rdata > peakVal) begin
                peakVal <= rdata;
                peakBin <= cmpAddr;
            end

            if (start) begin
                re <= 1'b1;
                raddr <= '0;
                peakBin <= '0;
                peakVal <= '0;
            end else if (re) begin
                raddr <= raddr + 1'b1; // wraps back to 0 after the last bin
                if (raddr == BinW'(NumBins - 1)) begin
                    re <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpAddr <= raddr; // follows the read latency
    end

endmodule

//--- hw/sifhCtrl.sv
module sifhCtrl #(
    parameter int NumEvents = 32
) (
    input  logic                       clk,
    input  logic                       res,
    input  sifhPkg::tdcCode_u          eventCode,
    input  logic                       eventValid,
    input  logic                       builderIdle,
    input  logic                       found,
    input  logic [sifhPkg::BinW-1:0]   peakBin,
    input  logic [sifhPkg::CountW-1:0] peakVal,
    output logic                       photonReq,
    output logic                       binValid,
    output logic [sifhPkg::BinW-1:0]   binIndex,
    output logic                       clrWe,
    output logic [sifhPkg::BinW-1:0]   clrAddr,
    output logic                       scanStart,
    output logic                       ramSel,
    output logic                       done,
    output logic [sifhPkg::BinW-1:0]   peakCoarse,
    output logic [sifhPkg::BinW-1:0]   peakFine,
    output logic [sifhPkg::CountW-1:0] peakCount
);
    import sifhPkg::*;

    localparam int CntW = $clog2(NumEvents + 1);

    localparam logic [2:0] sClear   = 3'd0;
    localparam logic [2:0] sCollect = 3'd1;
    localparam logic [2:0] sDrain   = 3'd2;
    localparam logic [2:0] sScan    = 3'd3;
    localparam logic [2:0] sIdle    = 3'd4;

    logic [2:0]      state;
    logic            finePass; // second pass of clear, collect, drain, scan
    logic [BinW-1:0] window;   // coarse peak from the first pass
    logic [CntW-1:0] evCnt;
    logic            accepted;
    logic            inWindow;

    assign accepted = photonReq & eventValid;
    assign inWindow = ~finePass | (eventCode.fine.window == window);

    // out-of-window codes still count toward NumEvents
    assign binValid = accepted & inWindow;
    assign binIndex = finePass ? eventCode.fine.fineBin : eventCode.coarse.coarseBin;

    assign scanStart = (state == sDrain) & builderIdle;
    assign ramSel = (state == sScan); // finder owns the read port

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sClear;
            finePass <= 1'b0;
            window <= '0;
            evCnt <= '0;
            photonReq <= 1'b0;
            clrWe <= 1'b0;
            clrAddr <= '0;
            done <= 1'b0;
            peakCoarse <= '0;
            peakFine <= '0;
            peakCount <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                sClear: begin
                    clrWe <= 1'b1;
                    if (clrWe) begin
                        clrAddr <= clrAddr + 1'b1; // back at 0 for the next clear
                        if (clrAddr == BinW'(NumBins - 1)) begin
                            clrWe <= 1'b0;
                            photonReq <= 1'b1;
                            state <= sCollect;
                        end
                    end
                end
                sCollect: begin
                    if (accepted) begin
                        if (evCnt == CntW'(NumEvents - 1)) begin
                            evCnt <= '0;
                            photonReq <= 1'b0;
                            state <= sDrain;
                        end else begin
                            evCnt <= evCnt + 1'b1;
                        end
                    end
                end
                sDrain: begin
                    if (builderIdle) begin
                        state <= sScan; // last write has landed
                    end
                end
                sScan: begin
                    if (found) begin
                        if (!finePass) begin
                            window <= peakBin;
                            finePass <= 1'b1;
                            clrWe <= 1'b1; // start the second clear at once
                            state <= sClear;
                        end else begin
                            peakCoarse <= window;
                            peakFine <= peakBin;
                            peakCount <= peakVal;
                            done <= 1'b1;
                            state <= sIdle;
                        end
                    end
                end
                default: begin
                    state <= sIdle; // hold results until reset
                end
            endcase
        end
    end

endmodule

//--- hw/sifhTop.sv
module sifhTop #(
    parameter int NumEvents = 32
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic [sifhPkg::CodeW-1:0]  eventCode,
    input  logic                       eventValid,
    output logic                       photonReq,
    output logic                       done,
    output logic [sifhPkg::BinW-1:0]   peakCoarse,
    output logic [sifhPkg::BinW-1:0]   peakFine,
    output logic [sifhPkg::CountW-1:0] peakCount
);
    import sifhPkg::*;

    logic              binValid;
    logic [BinW-1:0]   binIndex;
    logic              clrWe;
    logic [BinW-1:0]   clrAddr;
    logic              scanStart;
    logic              ramSel;

    logic              bldRe;
    logic [BinW-1:0]   bldRaddr;
    logic              bldWe;
    logic [BinW-1:0]   bldWaddr;
    logic [CountW-1:0] bldWdata;
    logic              bldIdle;

    logic              fndRe;
    logic [BinW-1:0]   fndRaddr;
    logic              found;
    logic [BinW-1:0]   peakBin;
    logic [CountW-1:0] peakVal;

    logic              ramWe;
    logic [BinW-1:0]   ramWaddr;
    logic [CountW-1:0] ramWdata;
    logic              ramRe;
    logic [BinW-1:0]   ramRaddr;
    logic [CountW-1:0] ramRdata;

    // RAM port ownership follows the controller state
    assign ramWe = clrWe | bldWe;
    assign ramWaddr = clrWe ? clrAddr : bldWaddr;
    assign ramWdata = clrWe ? '0 : bldWdata; // clear writes zero
    assign ramRe = ramSel ? fndRe : bldRe;
    assign ramRaddr = ramSel ? fndRaddr : bldRaddr;

    sifhCtrl #(
        .NumEvents(NumEvents)
    ) i_ctrl (
        .clk(clk),
        .res(res),
        .eventCode(eventCode),
        .eventValid(eventValid),
        .builderIdle(bldIdle),
        .found(found),
        .peakBin(peakBin),
        .peakVal(peakVal),
        .photonReq(photonReq),
        .binValid(binValid),
        .binIndex(binIndex),
        .clrWe(clrWe),
        .clrAddr(clrAddr),
        .scanStart(scanStart),
        .ramSel(ramSel),
        .done(done),
        .peakCoarse(peakCoarse),
        .peakFine(peakFine),
        .peakCount(peakCount)
    );

    hisBuilder i_builder (
        .clk(clk),
        .res(res),
        .binValid(binValid),
        .binIndex(binIndex),
        .rdata(ramRdata),
        .re(bldRe),
        .raddr(bldRaddr),
        .we(bldWe),
        .waddr(bldWaddr),
        .wdata(bldWdata),
        .idle(bldIdle)
    );

    peakFinder i_finder (
        .clk(clk),
        .res(res),
        .start(scanStart),
        .rdata(ramRdata),
        .re(fndRe),
        .raddr(fndRaddr),
        .found(found),
        .peakBin(peakBin),
        .peakVal(peakVal)
    );

    hisRam i_ram (
        .clk(clk),
        .we(ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .re(ramRe),
        .raddr(ramRaddr),
        .rdata(ramRdata)
    );

endmodule

//--- verification/sifh_assertions.sv
module sifhAssertions (
    input logic clk,
    input logic res,
    input logic photonReq,
    input logic done,
    input logic clrWe,
    input logic bldWe,
    input logic binValid,
    input logic scanStart,
    input logic ramSel
);

    donePulse: assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else $error("done stayed high for more than one cycle");

    reqNotDone: assert property (@(posedge clk) disable iff (!res) !(photonReq && done))
        else $error("photonReq and done high in the same cycle");

    // clear and builder share one write port
    oneWriter: assert property (@(posedge clk) disable iff (!res) !(clrWe && bldWe))
        else $error("clear and builder both write the RAM");

    quietInReset: assert property (@(posedge clk)
        !res |-> !(photonReq | done | clrWe | bldWe | binValid | scanStart | ramSel))
        else $error("control output active during reset");

endmodule

bind sifhTop sifhAssertions i_assertions (.*);

//--- verification/sifhTb.sv
module sifhTb;
    import sifhPkg::*;

    localparam int NumEvents = 32;
    localparam int MaxRuns = 8;
    localparam int RunCycles = 2 * (16 + NumEvents * 4 + 20) + 20;

    logic              clk;
    logic              res;
    logic [CodeW-1:0]  eventCode;
    logic              eventValid;
    logic              photonReq;
    logic              done;
    logic [BinW-1:0]   peakCoarse;
    logic [BinW-1:0]   peakFine;
    logic [CountW-1:0] peakCount;

    string             runName [MaxRuns];
    int                runGap [MaxRuns];
    logic [CodeW-1:0]  runCode [MaxRuns][NumEvents];
    int                expCoarse [MaxRuns];
    int                expFine [MaxRuns];
    int                expCount [MaxRuns];
    int                numRuns;
    int                errors;
    int                cycleLimit;
    int                cycles = 0;
    int                doneTotal = 0; // done pulses since time 0

    sifhTop #(.NumEvents(NumEvents)) i_dut (
        .clk(clk),
        .res(res),
        .eventCode(eventCode),
        .eventValid(eventValid),
        .photonReq(photonReq),
        .done(done),
        .peakCoarse(peakCoarse),
        .peakFine(peakFine),
        .peakCount(peakCount)
    );

    always #4 clk = ~clk;

    task automatic failNow(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (done) begin
            doneTotal++;
        end
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            failNow($sformatf("timeout after %0d cycles, a run never finished", cycles));
        end
    end

    task automatic readRuns();
        int fd;
        int r;
        string line;
        numRuns = 0;
        fd = $fopen("verification/sifhInput.txt", "r");
        if (fd != 0) begin
            r = $fgets(line, fd); // two column header lines
            r = $fgets(line, fd);
            while (numRuns < MaxRuns &&
                   $fscanf(fd, "%s %d", runName[numRuns], runGap[numRuns]) == 2) begin
                for (int i = 0; i < NumEvents; i++) begin
                    r = $fscanf(fd, "%h", runCode[numRuns][i]);
                end
                r = $fscanf(fd, "%h %h %h", expCoarse[numRuns], expFine[numRuns],
                            expCount[numRuns]);
                numRuns++;
            end
            $fclose(fd);
        end
    endtask

    // coarse bin is code[9:6], window code[9:6], fine bin code[5:2]
    task automatic modelRun(input int run, output int c, output int f, output int n);
        int coarseHist [NumBins];
        int fineHist [NumBins];
        for (int b = 0; b < NumBins; b++) begin
            coarseHist[b] = 0;
            fineHist[b] = 0;
        end
        for (int i = 0; i < NumEvents; i++) begin
            coarseHist[runCode[run][i][9:6]]++;
        end
        c = 0;
        for (int b = 1; b < NumBins; b++) begin
            if (coarseHist[b] > coarseHist[c]) begin
                c = b; // first max
            end
        end
        for (int i = 0; i < NumEvents; i++) begin
            if (int'(runCode[run][i][9:6]) == c) begin
                fineHist[runCode[run][i][5:2]]++;
            end
        end
        f = 0;
        for (int b = 1; b < NumBins; b++) begin
            if (fineHist[b] > fineHist[f]) begin
                f = b;
            end
        end
        n = (fineHist[f] > 255) ? 255 : fineHist[f];
    endtask

    task automatic strayEvent(); // ignored while photonReq is low
        eventValid = 1'b1;
        eventCode = CodeW'($urandom);
    endtask

    task automatic sendPass(input int run);
        int idx;
        int gap;
        idx = 0;
        gap = 0;
        while (idx < NumEvents) begin
            @(negedge clk);
            if (!photonReq) begin
                strayEvent();
            end else if (gap > 0) begin
                eventValid = 1'b0;
                gap--;
            end else begin
                eventValid = 1'b1;
                eventCode = runCode[run][idx];
                idx++;
                gap = int'($urandom_range(runGap[run], 0));
            end
        end
        @(negedge clk);
        eventValid = 1'b0;
    endtask

    task automatic checkValue(input int run, input string what, input int expected,
                              input int actual);
        assert (actual == expected)
            else begin
                $display("ERROR %s %s: expected %0d, actual %0d", runName[run], what,
                         expected, actual);
                errors++;
            end
    endtask

    task automatic checkResults(input int run, input string when);
        checkValue(run, {"coarse ", when}, expCoarse[run], int'(peakCoarse));
        checkValue(run, {"fine ", when}, expFine[run], int'(peakFine));
        checkValue(run, {"count ", when}, expCount[run], int'(peakCount));
    endtask

    initial begin
        int seedDummy;
        int refC;
        int refF;
        int refN;
        int runErrors;
        int doneBefore;
        int failedRuns;
        clk = 1'b0;
        res = 1'b0;
        eventCode = '0;
        eventValid = 1'b0;
        errors = 0;
        failedRuns = 0;
        cycleLimit = 0;
        seedDummy = $urandom(42);
        readRuns();
        if (numRuns == 0) begin
            failNow("no test runs could be read from verification/sifhInput.txt");
        end else begin
            cycleLimit = numRuns * RunCycles;
            for (int run = 0; run < numRuns; run++) begin
                runErrors = errors;
                modelRun(run, refC, refF, refN);
                assert (refC == expCoarse[run] && refF == expFine[run] && refN == expCount[run])
                    else begin
                        $display("file error in %s: model gives %0d %0d %0d", runName[run],
                                 refC, refF, refN);
                        errors++;
                    end
                res = 1'b0;
                eventValid = 1'b0;
                repeat (3) @(negedge clk);
                res = 1'b1;
                @(negedge clk);
                assert (!photonReq && !done && peakCoarse == '0 && peakFine == '0 &&
                        peakCount == '0)
                    else begin
                        $display("%s: outputs not idle after reset", runName[run]);
                        errors++;
                    end
                doneBefore = doneTotal;
                sendPass(run); // coarse pass
                sendPass(run); // fine pass, same codes
                while (!done) begin
                    @(negedge clk);
                    strayEvent();
                end
                checkResults(run, "at done");
                repeat (4) begin
                    @(negedge clk);
                    strayEvent();
                end
                eventValid = 1'b0;
                checkResults(run, "held");
                assert (doneTotal - doneBefore == 1)
                    else begin
                        $display("%s: done pulsed %0d times", runName[run],
                                 doneTotal - doneBefore);
                        errors++;
                    end
                if (errors != runErrors) begin
                    failedRuns++;
                end
                $display("%s %s", runName[run], (errors == runErrors) ? "ok" : "bad");
            end
            $display("runs %0d, good %0d, bad %0d, errors %0d", numRuns, numRuns - failedRuns,
                     failedRuns, errors);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verification/sifhInput.txt
// columns: run name, max gap between events, 32 TDC codes in hex
// then the expected coarse peak bin, fine peak bin and fine peak count in hex
tieLow 3 250 0DC 144 0C8 251 0DD 148 0C9 252 0DE 14C 0CA 253 0DF 150 0CB
250 0DC 154 0C8 251 0E8 158 252 0E9 15C 253 160 250 251 252 253 3 2 05
window 3 03C 33C 1C4 300 03D 33D 1C8 320 03E 33E 1CC 301 03F 33F 1D0 321
03C 33C 1D4 302 03D 33D 1D8 322 03E 1DC 303 03F 1E0 323 03C 03D c f 06
burst 0 1A4 1A4 1A5 1A6 1A7 1A4 1A4 1A5 064 064 065 066 067 064 18C 18C
18D 18E 18F 18C 18C 1A6 1A6 1A7 1A7 1A4 064 064 065 065 066 067 6 9 0d
identical 3 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9
2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 2A9 a a 20

//--- tb.f
hw/sifhPkg.sv
hw/hisRam.sv
hw/hisBuilder.sv
hw/peakFinder.sv
hw/sifhCtrl.sv
hw/sifhTop.sv
verification/sifh_assertions.sv
verification/sifhTb.sv

//--- Makefile
SIMLOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module sifhTb -f tb.f

sim:
	verilator --binary --timing --assert -j 0 --top-module sifhTb -Mdir obj_dir -f tb.f
	./obj_dir/VsifhTb | tee $(SIMLOG)
	grep -q "SIMULATION PASSED" $(SIMLOG)

clean:
	rm -rf obj_dir $(SIMLOG)
